// File: tb.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/apb_pkg.sv
verilog/line_memory.sv
verilog/dm_cache.sv
verilog/cache_regs.sv
verilog/cache_subsys.sv
test/cache_assert.sv
test/tb_cache_subsys.sv

// File: test/cache_assert.sv
`timescale 1ns/1ps

module cache_assert (
    input logic clk,
    input logic rst,
    input logic cpu_ready,
    input logic mem_req,
    input logic mem_ready,
    input logic hit,
    input logic miss
);

    logic mem_pending; // High from a memory request until its ready

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            mem_pending <= 1'b0;
        else if (mem_req)
            mem_pending <= 1'b1;
        else if (mem_ready)
            mem_pending <= 1'b0;
    end

    // **************************************************
    // Handshake properties
    // **************************************************
    cpu_ready_pulse: assert property (@(posedge clk) disable iff (!rst)
        cpu_ready |=> !cpu_ready)
        else $error("cpu_ready stayed high for more than one cycle");

    mem_ready_pulse: assert property (@(posedge clk) disable iff (!rst)
        mem_ready |=> !mem_ready)
        else $error("mem_ready stayed high for more than one cycle");

    mem_req_idle: assert property (@(posedge clk) disable iff (!rst)
        mem_req |-> !mem_pending)
        else $error("mem_req issued while a memory access was pending");

    hit_miss_excl: assert property (@(posedge clk) disable iff (!rst)
        !(hit && miss))
        else $error("hit and miss were high in the same cycle");

endmodule

bind dm_cache cache_assert u_assert (
    .clk(clk), .rst(rst), .cpu_ready(cpu_ready), .mem_req(mem_req),
    .mem_ready(mem_ready), .hit(hit), .miss(miss)
);

// File: test/tb_cache_subsys.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_cache_subsys;

    localparam int WAIT_LIMIT  = 100; // Longer than any single CPU access
    localparam int FLUSH_POLLS = 40;

    logic                    clk;
    logic                    rst;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    apb_pkg::apb_addr_t      paddr;
    apb_pkg::apb_data_t      pwdata;
    apb_pkg::apb_data_t      prdata;
    logic                    pready;
    logic                    pslverr;
    logic                    cpu_req;
    logic                    cpu_we;
    cache_pkg::addr_t        cpu_addr;
    cache_pkg::word_t        cpu_wdata;
    cache_pkg::word_t        cpu_rdata;
    logic                    cpu_ready;

    cache_pkg::word_t        shadow [`MEM_WORDS];
    cache_pkg::tag_t         tag_map [`CACHE_LINES]; // Tag held at each index
    logic [`CACHE_LINES-1:0] map_valid;
    logic                    cache_on;
    int                      exp_hits;
    int                      exp_misses;
    integer                  seed = 32'h1704_15f8;

    cache_subsys i_cache_subsys (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr),
        .cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata), .cpu_rdata(cpu_rdata), .cpu_ready(cpu_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (got !== exp)
            stop_run($sformatf("Error %s exp %h got %h", name, exp, got));
    endtask

    // Memory contents as the CPU should see them
    function automatic cache_pkg::word_t expected_word(input cache_pkg::addr_t addr);
        return shadow[addr[11:2]];
    endfunction

    // **************************************************
    // APB and CPU drivers
    // **************************************************
    task automatic apb_write(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1; // Zero wait states, so the next edge completes it
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input apb_pkg::apb_addr_t addr, output apb_pkg::apb_data_t data,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        check_value("pready", 32'd1, 32'(pready));
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_expect(input apb_pkg::apb_addr_t addr, input string name,
                              input apb_pkg::apb_data_t exp);
        apb_pkg::apb_data_t data;
        logic               err;
        apb_read(addr, data, err);
        check_value("pslverr", 32'd0, 32'(err));
        check_value(name, exp, data);
    endtask

    task automatic cpu_access(input logic we, input cache_pkg::addr_t addr,
                              input cache_pkg::word_t wdata,
                              output cache_pkg::word_t rdata, output int cycles);
        @(negedge clk);
        cpu_req   = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cycles    = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT)
                stop_run($sformatf("Timeout waiting for cpu_ready at address %h", addr));
        end while (!cpu_ready);
        cpu_req = 1'b0; // Address and direction stay for the compare process
        rdata   = cpu_rdata;
        if (we)
            shadow[addr[11:2]] = wdata;
    endtask

    task automatic read_word(input cache_pkg::addr_t addr, output cache_pkg::word_t data,
                             output int cycles);
        cache_pkg::index_t idx;
        cache_pkg::tag_t   tag;
        idx = addr[7:4];
        tag = addr[11:8];
        cpu_access(1'b0, addr, '0, data, cycles);
        if (cache_on) begin
            if (map_valid[idx] && tag_map[idx] == tag) begin
                exp_hits++;
            end else begin
                exp_misses++; // First touch, or the index held another tag
                map_valid[idx] = 1'b1;
                tag_map[idx]   = tag;
            end
        end
    endtask

    task automatic write_word(input cache_pkg::addr_t addr, input cache_pkg::word_t data);
        cache_pkg::word_t unused;
        int               cycles;
        cpu_access(1'b1, addr, data, unused, cycles);
    endtask

    task automatic check_counters();
        reg_expect(`REG_HITS, "HITS", apb_pkg::apb_data_t'(exp_hits));
        reg_expect(`REG_MISSES, "MISSES", apb_pkg::apb_data_t'(exp_misses));
    endtask

    // Compare process for every completed CPU read
    always @(negedge clk) begin
        if (rst && cpu_ready && !cpu_we)
            check_value("cpu_rdata", expected_word(cpu_addr), cpu_rdata);
    end

    // **************************************************
    // Test sequence
    // **************************************************
    initial begin
        apb_pkg::apb_data_t rd;
        apb_pkg::apb_data_t rd2;
        logic               err;
        cache_pkg::addr_t   addr;
        cache_pkg::word_t   data;
        cache_pkg::word_t   wdata;
        cache_pkg::tag_t    tag;
        logic [2:0]         pick;
        int                 cycles;
        int                 polls;

        rst        = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        cpu_req    = 1'b0;
        cpu_we     = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        map_valid  = '0;
        cache_on   = 1'b0;
        exp_hits   = 0;
        exp_misses = 0;
        for (int i = 0; i < `MEM_WORDS; i++)
            shadow[i] = cache_pkg::word_t'(i);
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // Register state after reset and an unmapped offset
        reg_expect(`REG_CTRL, "CTRL", 32'h0);
        reg_expect(`REG_STATUS, "STATUS", 32'h0);
        check_counters();
        apb_read(8'h10, rd, err);
        check_value("pslverr", 32'd1, 32'(err));

        // Random reads over 8 lines, two tags share each index
        apb_write(`REG_CTRL, 32'h1);
        cache_on = 1'b1;
        for (int i = 0; i < 40; i++) begin
            pick = 3'($random(seed));
            addr = {20'h0, (pick[2] ? 4'h5 : 4'h0), 2'b00, pick[1:0], 2'($random(seed)), 2'b00};
            read_word(addr, data, cycles);
        end
        apb_read(`REG_HITS, rd, err);
        apb_read(`REG_MISSES, rd2, err);
        check_value("HITS+MISSES", 32'd40, rd + rd2);
        check_counters();

        // Writes followed by reads, every other write into the line just read
        for (int i = 0; i < 16; i++) begin
            wdata = $random(seed);
            if (i % 2 == 0)
                addr = {addr[31:4], 2'($random(seed)), 2'b00}; // Cached line, so a hit
            else
                addr = 32'($random(seed)) & 32'h0000_0FFC;
            write_word(addr, wdata);
            read_word(addr, data, cycles);
            check_value("cpu_rdata", wdata, data);
        end
        check_counters();

        // A miss and then a hit on the same word
        tag  = map_valid[9] ? tag_map[9] + 1'b1 : 4'h6;
        addr = {20'h0, tag, 4'd9, 4'h8};
        read_word(addr, data, cycles);
        apb_read(`REG_HITS, rd, err);
        read_word(addr, data, cycles);
        check_value("hit latency", 32'd2, 32'(cycles));
        apb_read(`REG_HITS, rd2, err);
        check_value("HITS", rd + 32'd1, rd2);

        // Flush, then the same line misses again
        apb_write(`REG_CTRL, 32'h3);
        reg_expect(`REG_STATUS, "STATUS", 32'h1);
        polls = 0;
        do begin
            apb_read(`REG_STATUS, rd, err);
            polls++;
            if (polls > FLUSH_POLLS)
                stop_run("Timeout waiting for flush_busy to clear after a flush");
        end while (rd[0]);
        map_valid = '0;
        reg_expect(`REG_CTRL, "CTRL", 32'h1);
        apb_read(`REG_MISSES, rd, err);
        read_word(addr, data, cycles);
        apb_read(`REG_MISSES, rd2, err);
        check_value("MISSES", rd + 32'd1, rd2);
        check_counters();
        apb_write(`REG_CTRL, 32'h5);
        exp_hits   = 0;
        exp_misses = 0;
        check_counters();

        // Reads with the cache disabled leave the counters alone
        apb_write(`REG_CTRL, 32'h0);
        cache_on = 1'b0;
        for (int i = 0; i < 12; i++) begin
            addr = 32'($random(seed)) & 32'h0000_0FFC;
            read_word(addr, data, cycles);
        end
        check_counters();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: verilog/apb_pkg.sv
package apb_pkg;

    // Register offsets share the address type
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

endpackage

// File: verilog/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// **************************************************
// Memory and cache geometry
// **************************************************
`define MEM_WORDS       1024 // 32-bit words in main memory
`define CACHE_LINES     16   // Each line holds 4 words

// Memory latencies in clock cycles from mem_req to mem_ready
`define MEM_READ_DELAY  12
`define MEM_WRITE_DELAY 6

// **************************************************
// APB register byte offsets
// **************************************************
`define REG_CTRL        8'h00
`define REG_STATUS      8'h04
`define REG_HITS        8'h08
`define REG_MISSES      8'h0C

`endif

// File: verilog/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

    typedef logic [31:0]  addr_t; // CPU byte address
    typedef logic [31:0]  word_t;
    typedef logic [127:0] line_t; // Word 0 sits in bits 31:0

    // Line index comes from address bits 7:4
    typedef logic [$clog2(`CACHE_LINES)-1:0] index_t;

    // Tag covers the address bits above the index that reach into memory
    typedef logic [$clog2(`MEM_WORDS) - $clog2(`CACHE_LINES) - 3:0] tag_t;

    typedef enum logic [2:0] {
        IDLE,   // Waits for a request or a flush
        LOOKUP, // Tag compare
        FILL,   // Line read from memory in flight
        WRITE,  // Write-through in flight
        FLUSH   // Clears one valid bit per cycle
    } cache_state_t;

endpackage

// File: verilog/cache_regs.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  apb_pkg::apb_addr_t paddr,
    input  apb_pkg::apb_data_t pwdata,
    output apb_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               enable,
    output logic               flush_start,
    input  logic               flush_busy,
    input  logic               hit,
    input  logic               miss
);

    apb_pkg::apb_data_t hit_count;
    apb_pkg::apb_data_t miss_count;
    logic               access;
    logic               ctrl_wr;
    logic               known;

    assign access  = psel && penable;
    assign ctrl_wr = access && pwrite && (paddr == `REG_CTRL);

    // **************************************************
    // Read decode
    // **************************************************
    always_comb begin
        known  = 1'b1;
        prdata = '0;
        case (paddr)
            `REG_CTRL:   prdata = apb_pkg::apb_data_t'(enable); // Command bits read as 0
            `REG_STATUS: prdata = apb_pkg::apb_data_t'(flush_busy);
            `REG_HITS:   prdata = hit_count;
            `REG_MISSES: prdata = miss_count;
            default:     known  = 1'b0;
        endcase
    end

    assign pready  = 1'b1; // No wait states
    assign pslverr = access && !known;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            enable      <= 1'b0;
            flush_start <= 1'b0;
        end else begin
            flush_start <= ctrl_wr && pwdata[1];
            if (ctrl_wr)
                enable <= pwdata[0];
        end
    end

    // Statistics counters wrap around
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else if (ctrl_wr && pwdata[2]) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            if (hit)
                hit_count <= hit_count + 1'b1;
            if (miss)
                miss_count <= miss_count + 1'b1;
        end
    end

endmodule

// File: verilog/cache_subsys.sv
`timescale 1ns/1ps

module cache_subsys (
    input  logic               clk,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  apb_pkg::apb_addr_t paddr,
    input  apb_pkg::apb_data_t pwdata,
    output apb_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    input  logic               cpu_req,
    input  logic               cpu_we,
    input  cache_pkg::addr_t   cpu_addr,
    input  cache_pkg::word_t   cpu_wdata,
    output cache_pkg::word_t   cpu_rdata,
    output logic               cpu_ready
);

    logic             enable;
    logic             flush_start;
    logic             flush_busy;
    logic             hit;
    logic             miss;
    logic             mem_req;
    logic             mem_we;
    cache_pkg::addr_t mem_addr;
    cache_pkg::word_t mem_wdata;
    cache_pkg::line_t mem_line;
    logic             mem_ready;

    // **************************************************
    // Register block, cache and backing memory
    // **************************************************
    cache_regs u_regs (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr),
        .enable(enable), .flush_start(flush_start),
        .flush_busy(flush_busy), .hit(hit), .miss(miss)
    );

    dm_cache u_cache (
        .clk(clk), .rst(rst),
        .cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata), .cpu_rdata(cpu_rdata), .cpu_ready(cpu_ready),
        .enable(enable), .flush_start(flush_start), .flush_busy(flush_busy),
        .hit(hit), .miss(miss),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_line(mem_line), .mem_ready(mem_ready)
    );

    line_memory u_mem (
        .clk(clk), .rst(rst),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_line(mem_line), .mem_ready(mem_ready)
    );

endmodule

// File: verilog/dm_cache.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module dm_cache (
    input  logic             clk,
    input  logic             rst,
    input  logic             cpu_req,
    input  logic             cpu_we,
    input  cache_pkg::addr_t cpu_addr,
    input  cache_pkg::word_t cpu_wdata,
    output cache_pkg::word_t cpu_rdata,
    output logic             cpu_ready,
    input  logic             enable,
    input  logic             flush_start,
    output logic             flush_busy,
    output logic             hit,
    output logic             miss,
    output logic             mem_req,
    output logic             mem_we,
    output cache_pkg::addr_t mem_addr,
    output cache_pkg::word_t mem_wdata,
    input  cache_pkg::line_t mem_line,
    input  logic             mem_ready
);

    localparam int IDX_LSB = 4; // Above the 16-byte line offset
    localparam int TAG_LSB = IDX_LSB + $bits(cache_pkg::index_t);
    localparam int WORD_W  = $bits(cache_pkg::word_t);
    localparam cache_pkg::index_t LAST_LINE = cache_pkg::index_t'(`CACHE_LINES - 1);

    cache_pkg::cache_state_t state;
    logic [`CACHE_LINES-1:0] valid;
    cache_pkg::tag_t         tags  [`CACHE_LINES];
    cache_pkg::line_t        lines [`CACHE_LINES];
    cache_pkg::index_t       idx;
    cache_pkg::tag_t         tag;
    logic [1:0]              offset;
    logic                    lookup_hit;
    logic                    flush_pend;
    cache_pkg::index_t       flush_idx;

    assign idx        = cpu_addr[TAG_LSB-1:IDX_LSB];
    assign tag        = cpu_addr[TAG_LSB +: $bits(cache_pkg::tag_t)];
    assign offset     = cpu_addr[3:2];
    assign lookup_hit = enable && valid[idx] && (tags[idx] == tag);

    // The requester holds its fields until cpu_ready, so memory sees them directly
    assign mem_we    = cpu_we;
    assign mem_addr  = cpu_addr;
    assign mem_wdata = cpu_wdata;

    // **************************************************
    // Control FSM
    // **************************************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= cache_pkg::IDLE;
            valid      <= '0;
            cpu_ready  <= 1'b0;
            mem_req    <= 1'b0;
            hit        <= 1'b0;
            miss       <= 1'b0;
            flush_busy <= 1'b0;
            flush_idx  <= '0;
            flush_pend <= 1'b0;
        end else begin
            cpu_ready <= 1'b0;
            mem_req   <= 1'b0;
            hit       <= 1'b0;
            miss      <= 1'b0;
            // A flush command during a CPU access runs once the access ends
            if (flush_start && state != cache_pkg::IDLE && state != cache_pkg::FLUSH)
                flush_pend <= 1'b1;
            case (state)
                cache_pkg::IDLE: begin
                    if (flush_start || flush_pend) begin
                        state      <= cache_pkg::FLUSH;
                        flush_busy <= 1'b1;
                        flush_idx  <= '0;
                        flush_pend <= 1'b0;
                    end else if (cpu_req && !cpu_ready) begin // Skip the request just served
                        state <= cache_pkg::LOOKUP;
                    end
                end
                cache_pkg::LOOKUP: begin
                    if (cpu_we) begin
                        mem_req <= 1'b1;
                        state   <= cache_pkg::WRITE;
                    end else if (lookup_hit) begin
                        cpu_ready <= 1'b1;
                        hit       <= 1'b1;
                        state     <= cache_pkg::IDLE;
                    end else begin
                        mem_req <= 1'b1;
                        miss    <= enable; // Only reads are counted
                        state   <= cache_pkg::FILL;
                    end
                end
                cache_pkg::FILL: begin
                    if (mem_ready) begin
                        if (enable)
                            valid[idx] <= 1'b1;
                        cpu_ready <= 1'b1;
                        state     <= cache_pkg::IDLE;
                    end
                end
                cache_pkg::WRITE: begin
                    if (mem_ready) begin
                        cpu_ready <= 1'b1;
                        state     <= cache_pkg::IDLE;
                    end
                end
                cache_pkg::FLUSH: begin
                    valid[flush_idx] <= 1'b0;
                    flush_idx        <= flush_idx + 1'b1;
                    if (flush_idx == LAST_LINE) begin
                        flush_busy <= 1'b0;
                        state      <= cache_pkg::IDLE;
                    end
                end
                default: state <= cache_pkg::IDLE;
            endcase
        end
    end

    // Tag and line storage plus the read data register
    always_ff @(posedge clk) begin
        if (state == cache_pkg::LOOKUP && !cpu_we && lookup_hit)
            cpu_rdata <= lines[idx][offset * WORD_W +: WORD_W];
        if (state == cache_pkg::LOOKUP && cpu_we && lookup_hit)
            lines[idx][offset * WORD_W +: WORD_W] <= cpu_wdata;
        if (state == cache_pkg::FILL && mem_ready) begin
            cpu_rdata <= mem_line[offset * WORD_W +: WORD_W];
            if (enable) begin
                tags[idx]  <= tag;
                lines[idx] <= mem_line;
            end
        end
    end

endmodule

// File: verilog/line_memory.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module line_memory (
    input  logic             clk,
    input  logic             rst,
    input  logic             mem_req,
    input  logic             mem_we,
    input  cache_pkg::addr_t mem_addr,
    input  cache_pkg::word_t mem_wdata,
    output cache_pkg::line_t mem_line,
    output logic             mem_ready
);

    localparam int WADDR_W = $clog2(`MEM_WORDS);
    localparam int CNT_W   = $clog2(`MEM_READ_DELAY + 1);

    cache_pkg::word_t   mem [`MEM_WORDS];
    logic               busy;
    logic [CNT_W-1:0]   count;
    logic               done;
    logic               pend_we;
    logic [WADDR_W-1:0] pend_addr;
    cache_pkg::word_t   pend_wdata;
    logic [WADDR_W-3:0] line_hi;

    // Word i holds the value i after power-up
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = cache_pkg::word_t'(i);
        end
    end

    assign done    = busy && (count == CNT_W'(1));
    assign line_hi = pend_addr[WADDR_W-1:2];

    // **************************************************
    // Latency counter
    // **************************************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy      <= 1'b0;
            count     <= '0;
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= 1'b0;
            if (!busy) begin
                if (mem_req) begin // A request while busy is dropped
                    busy  <= 1'b1;
                    count <= mem_we ? CNT_W'(`MEM_WRITE_DELAY - 1)
                                    : CNT_W'(`MEM_READ_DELAY - 1);
                end
            end else if (done) begin
                busy      <= 1'b0;
                mem_ready <= 1'b1;
            end else begin
                count <= count - CNT_W'(1);
            end
        end
    end

    always @(posedge clk) begin
        if (!busy && mem_req) begin
            pend_we    <= mem_we;
            pend_addr  <= mem_addr[WADDR_W+1:2];
            pend_wdata <= mem_wdata;
        end
        if (done && pend_we)
            mem[pend_addr] <= pend_wdata;
        if (done && !pend_we) begin
            mem_line <= {mem[{line_hi, 2'd3}], mem[{line_hi, 2'd2}],
                         mem[{line_hi, 2'd1}], mem[{line_hi, 2'd0}]};
        end
    end

endmodule
